// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing
TOP   = decodeTb
FILES = sources.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILES)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null

clean:
	rm -rf obj_dir

// ==== rtl/decodeStage.sv ====
// Instruction decode stage
// Decodes the instruction, forwards operands from EX and MEM, picks the
// destination register and early write data, decrements Tnew and latches
// everything into the ID/EX pipeline register with stall and clear

`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module decodeStage (
    input  wire logic                        clk,
    input  wire logic                        rstN,
    input  wire logic                        stall,
    input  wire logic                        clr,
    input  wire logic [31:0]                 instrId,
    input  wire logic [`DATA_WIDTH-1:0]      pcId,
    input  wire logic [`TNEW_WIDTH-1:0]      tnewId,
    input  wire logic [`REG_ADDR_WIDTH-1:0]  fwdAddrEx,
    input  wire logic [`DATA_WIDTH-1:0]      fwdDataEx,
    input  wire logic [`REG_ADDR_WIDTH-1:0]  fwdAddrMem,
    input  wire logic [`DATA_WIDTH-1:0]      fwdDataMem,
    input  wire logic [`DATA_WIDTH-1:0]      rdData1,
    input  wire logic [`DATA_WIDTH-1:0]      rdData2,
    // Register file and next-PC unit
    output logic [`REG_ADDR_WIDTH-1:0]       rdAddr1,
    output logic [`REG_ADDR_WIDTH-1:0]       rdAddr2,
    output mipsPkg::instrOp_e                opId,
    output logic [`DATA_WIDTH-1:0]           rsDataFwd,
    output logic [`DATA_WIDTH-1:0]           rtDataFwd,
    output logic [15:0]                      imm16Id,
    output logic [25:0]                      jmpAddrId,
    // Hazard unit
    output logic [`REG_ADDR_WIDTH-1:0]       rsId,
    output logic [`REG_ADDR_WIDTH-1:0]       rtId,
    // ID/EX register
    output mipsPkg::instrOp_e                opEx,
    output logic [`DATA_WIDTH-1:0]           pcEx,
    output logic [`DATA_WIDTH-1:0]           rsDataEx,
    output logic [`DATA_WIDTH-1:0]           rtDataEx,
    output logic [15:0]                      imm16Ex,
    output logic [4:0]                       shamtEx,
    output logic [`REG_ADDR_WIDTH-1:0]       rsEx,
    output logic [`REG_ADDR_WIDTH-1:0]       rtEx,
    output logic [`REG_ADDR_WIDTH-1:0]       regWriteAddrEx,
    output logic [`DATA_WIDTH-1:0]           regWriteDataEx,
    output logic [`TNEW_WIDTH-1:0]           tnewEx
);

    logic [`REG_ADDR_WIDTH-1:0] rdId;
    logic [4:0]                 shamtId;
    mipsPkg::instrClass_e       classId;
    logic [`REG_ADDR_WIDTH-1:0] regWriteAddr;
    logic [`DATA_WIDTH-1:0]     regWriteData;
    logic [`TNEW_WIDTH-1:0]     tnewNext;

    instrDecoder uDecoder (
        .instr   (instrId),
        .op      (opId),
        .rs      (rsId),
        .rt      (rtId),
        .rd      (rdId),
        .shamt   (shamtId),
        .imm16   (imm16Id),
        .jmpAddr (jmpAddrId)
    );

    instrClassify uClassify (
        .op         (opId),
        .instrClass (classId)
    );

    assign rdAddr1 = rsId;
    assign rdAddr2 = rtId;

    // EX result beats MEM result, register 0 is never forwarded
    assign rsDataFwd = (fwdAddrEx == rsId && fwdAddrEx != '0)   ? fwdDataEx  :
                       (fwdAddrMem == rsId && fwdAddrMem != '0) ? fwdDataMem : rdData1;
    assign rtDataFwd = (fwdAddrEx == rtId && fwdAddrEx != '0)   ? fwdDataEx  :
                       (fwdAddrMem == rtId && fwdAddrMem != '0) ? fwdDataMem : rdData2;

    always_comb begin
        if (opId == mipsPkg::JAL) begin
            regWriteAddr = `LINK_REG;
        end else if (classId == mipsPkg::CALC_R || opId == mipsPkg::JALR) begin
            regWriteAddr = rdId;
        end else if (classId == mipsPkg::CALC_I || classId == mipsPkg::MEM_READ) begin
            regWriteAddr = rtId;
        end else begin
            regWriteAddr = '0;
        end
    end

    // Link address and LUI value are known already in ID
    assign regWriteData = (opId == mipsPkg::JAL || opId == mipsPkg::JALR) ? pcId + 32'd8 :
                          (opId == mipsPkg::LUI) ? {imm16Id, 16'h0000} : '0;

    assign tnewNext = (tnewId == '0) ? '0 : tnewId - `TNEW_WIDTH'(1);

    always_ff @(posedge clk) begin
        if (!rstN || clr) begin
            opEx           <= mipsPkg::NOP;
            pcEx           <= '0;
            rsDataEx       <= '0;
            rtDataEx       <= '0;
            imm16Ex        <= '0;
            shamtEx        <= '0;
            rsEx           <= '0;
            rtEx           <= '0;
            regWriteAddrEx <= '0;
            regWriteDataEx <= '0;
            tnewEx         <= '0;
        end else if (!stall) begin
            opEx           <= opId;
            pcEx           <= pcId;
            rsDataEx       <= rsDataFwd;
            rtDataEx       <= rtDataFwd;
            imm16Ex        <= imm16Id;
            shamtEx        <= shamtId;
            rsEx           <= rsId;
            rtEx           <= rtId;
            regWriteAddrEx <= regWriteAddr;
            regWriteDataEx <= regWriteData;
            tnewEx         <= tnewNext;
        end
    end

    // A cleared slot must reach EX as a bubble
    assert property (@(posedge clk) clr |=> (opEx == mipsPkg::NOP && regWriteAddrEx == '0));

endmodule

`default_nettype wire

// ==== rtl/decodeTop.sv ====
// Decode subsystem top level
// Connects the decode stage, the register file and the next-PC unit

`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module decodeTop (
    input  wire logic                        clk,
    input  wire logic                        rstN,
    input  wire logic                        stall,
    input  wire logic                        clr,
    input  wire logic [31:0]                 instrId,
    input  wire logic [`DATA_WIDTH-1:0]      pcId,
    input  wire logic [`TNEW_WIDTH-1:0]      tnewId,
    input  wire logic [`REG_ADDR_WIDTH-1:0]  fwdAddrEx,
    input  wire logic [`DATA_WIDTH-1:0]      fwdDataEx,
    input  wire logic [`REG_ADDR_WIDTH-1:0]  fwdAddrMem,
    input  wire logic [`DATA_WIDTH-1:0]      fwdDataMem,
    input  wire logic                        wbEn,
    input  wire logic [`REG_ADDR_WIDTH-1:0]  wbAddr,
    input  wire logic [`DATA_WIDTH-1:0]      wbData,
    output mipsPkg::instrOp_e                instrOpId,
    output logic [`REG_ADDR_WIDTH-1:0]       rsId,
    output logic [`REG_ADDR_WIDTH-1:0]       rtId,
    output logic                             branchTaken,
    output logic [`DATA_WIDTH-1:0]           nextPcOut,
    output mipsPkg::instrOp_e                opEx,
    output logic [`DATA_WIDTH-1:0]           pcEx,
    output logic [`DATA_WIDTH-1:0]           rsDataEx,
    output logic [`DATA_WIDTH-1:0]           rtDataEx,
    output logic [15:0]                      imm16Ex,
    output logic [4:0]                       shamtEx,
    output logic [`REG_ADDR_WIDTH-1:0]       rsEx,
    output logic [`REG_ADDR_WIDTH-1:0]       rtEx,
    output logic [`REG_ADDR_WIDTH-1:0]       regWriteAddrEx,
    output logic [`DATA_WIDTH-1:0]           regWriteDataEx,
    output logic [`TNEW_WIDTH-1:0]           tnewEx
);

    logic [`REG_ADDR_WIDTH-1:0] rdAddr1;
    logic [`REG_ADDR_WIDTH-1:0] rdAddr2;
    logic [`DATA_WIDTH-1:0]     rdData1;
    logic [`DATA_WIDTH-1:0]     rdData2;
    logic [`DATA_WIDTH-1:0]     rsDataFwd;
    logic [`DATA_WIDTH-1:0]     rtDataFwd;
    logic [15:0]                imm16Id;
    logic [25:0]                jmpAddrId;

    decodeStage uStage (
        .clk, .rstN, .stall, .clr, .instrId, .pcId, .tnewId,
        .fwdAddrEx, .fwdDataEx, .fwdAddrMem, .fwdDataMem,
        .rdData1, .rdData2, .rdAddr1, .rdAddr2,
        .opId (instrOpId),
        .rsDataFwd, .rtDataFwd, .imm16Id, .jmpAddrId, .rsId, .rtId,
        .opEx, .pcEx, .rsDataEx, .rtDataEx, .imm16Ex, .shamtEx,
        .rsEx, .rtEx, .regWriteAddrEx, .regWriteDataEx, .tnewEx
    );

    regFile uRegFile (
        .clk, .rstN, .rdAddr1, .rdAddr2, .rdData1, .rdData2,
        .wbEn, .wbAddr, .wbData
    );

    // Branch compare works on forwarded operands
    nextPc uNextPc (
        .op          (instrOpId),
        .rsData      (rsDataFwd),
        .rtData      (rtDataFwd),
        .pc          (pcId),
        .imm16       (imm16Id),
        .jmpAddr     (jmpAddrId),
        .branchTaken (branchTaken),
        .nextPcOut   (nextPcOut)
    );

endmodule

`default_nettype wire

// ==== rtl/instrClassify.sv ====
// Instruction classifier
// Groups operation symbols into classes for destination selection

`timescale 1ns/1ns
`default_nettype none

module instrClassify (
    input  mipsPkg::instrOp_e    op,
    output mipsPkg::instrClass_e instrClass
);

    always_comb begin
        case (op)
            mipsPkg::ADD, mipsPkg::SUB, mipsPkg::ADDU, mipsPkg::SUBU,
            mipsPkg::AND, mipsPkg::OR, mipsPkg::XOR, mipsPkg::NOR,
            mipsPkg::SLT, mipsPkg::SLTU,
            mipsPkg::SLL, mipsPkg::SLLV, mipsPkg::SRL, mipsPkg::SRLV,
            mipsPkg::SRA, mipsPkg::SRAV:
                instrClass = mipsPkg::CALC_R;
            // LUI counts as an immediate op writing rt
            mipsPkg::ADDI, mipsPkg::ADDIU, mipsPkg::ANDI, mipsPkg::ORI,
            mipsPkg::XORI, mipsPkg::LUI, mipsPkg::SLTI, mipsPkg::SLTIU:
                instrClass = mipsPkg::CALC_I;
            mipsPkg::LW, mipsPkg::LH, mipsPkg::LHU, mipsPkg::LB, mipsPkg::LBU:
                instrClass = mipsPkg::MEM_READ;
            mipsPkg::SW, mipsPkg::SH, mipsPkg::SB:
                instrClass = mipsPkg::MEM_WRITE;
            mipsPkg::BEQ, mipsPkg::BNE, mipsPkg::BLEZ, mipsPkg::BGTZ,
            mipsPkg::BGEZ, mipsPkg::BLTZ:
                instrClass = mipsPkg::BRANCH;
            mipsPkg::J, mipsPkg::JAL, mipsPkg::JR, mipsPkg::JALR:
                instrClass = mipsPkg::JUMP;
            default:
                instrClass = mipsPkg::NONE;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/instrDecoder.sv ====
// Instruction decoder
// Slices a MIPS instruction word into its fields and maps opcode, funct
// and the REGIMM rt field onto an operation symbol

`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  wire logic [31:0]      instr,
    output mipsPkg::instrOp_e     op,
    output logic [4:0]            rs,
    output logic [4:0]            rt,
    output logic [4:0]            rd,
    output logic [4:0]            shamt,
    output logic [15:0]           imm16,
    output logic [25:0]           jmpAddr
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode  = instr[31:26];
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];
    assign shamt   = instr[10:6];
    assign funct   = instr[5:0];
    assign imm16   = instr[15:0];
    assign jmpAddr = instr[25:0];

    always_comb begin
        op = mipsPkg::NOP;
        if (instr != 32'h0000_0000) begin
            case (opcode)
                // SPECIAL group, selected by funct
                6'b000000: begin
                    case (funct)
                        6'b100000: op = mipsPkg::ADD;
                        6'b100010: op = mipsPkg::SUB;
                        6'b100001: op = mipsPkg::ADDU;
                        6'b100011: op = mipsPkg::SUBU;
                        6'b100100: op = mipsPkg::AND;
                        6'b100101: op = mipsPkg::OR;
                        6'b100110: op = mipsPkg::XOR;
                        6'b100111: op = mipsPkg::NOR;
                        6'b101010: op = mipsPkg::SLT;
                        6'b101011: op = mipsPkg::SLTU;
                        6'b000000: op = mipsPkg::SLL;
                        6'b000100: op = mipsPkg::SLLV;
                        6'b000010: op = mipsPkg::SRL;
                        6'b000110: op = mipsPkg::SRLV;
                        6'b000011: op = mipsPkg::SRA;
                        6'b000111: op = mipsPkg::SRAV;
                        6'b001000: op = mipsPkg::JR;
                        6'b001001: op = mipsPkg::JALR;
                        default:   op = mipsPkg::NOP;
                    endcase
                end
                // REGIMM, rt picks the branch
                6'b000001: begin
                    if (rt == 5'b00001) begin
                        op = mipsPkg::BGEZ;
                    end else if (rt == 5'b00000) begin
                        op = mipsPkg::BLTZ;
                    end
                end
                6'b001000: op = mipsPkg::ADDI;
                6'b001001: op = mipsPkg::ADDIU;
                6'b001100: op = mipsPkg::ANDI;
                6'b001101: op = mipsPkg::ORI;
                6'b001110: op = mipsPkg::XORI;
                6'b001111: op = mipsPkg::LUI;
                6'b001010: op = mipsPkg::SLTI;
                6'b001011: op = mipsPkg::SLTIU;
                6'b100011: op = mipsPkg::LW;
                6'b100001: op = mipsPkg::LH;
                6'b100101: op = mipsPkg::LHU;
                6'b100000: op = mipsPkg::LB;
                6'b100100: op = mipsPkg::LBU;
                6'b101011: op = mipsPkg::SW;
                6'b101001: op = mipsPkg::SH;
                6'b101000: op = mipsPkg::SB;
                6'b000100: op = mipsPkg::BEQ;
                6'b000101: op = mipsPkg::BNE;
                6'b000110: op = mipsPkg::BLEZ;
                6'b000111: op = mipsPkg::BGTZ;
                6'b000010: op = mipsPkg::J;
                6'b000011: op = mipsPkg::JAL;
                default:   op = mipsPkg::NOP;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mipsPkg.sv ====
// MIPS decode package
// Operation symbols produced by the decoder and the instruction classes
// used for destination register selection

`default_nettype none

package mipsPkg;

    // Operation symbols, NOP must stay at zero
    typedef enum logic [5:0] {
        NOP = 6'd0,
        // R-type ALU and shifts
        ADD, SUB, ADDU, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU,
        SLL, SLLV, SRL, SRLV, SRA, SRAV,
        // Register jumps
        JR, JALR,
        // Immediate ALU
        ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU,
        // Loads
        LW, LH, LHU, LB, LBU,
        // Stores
        SW, SH, SB,
        // Branches
        BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ,
        // Direct jumps
        J, JAL
    } instrOp_e;

    // Instruction classes
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        CALC_R    = 3'd1,
        CALC_I    = 3'd2,
        MEM_READ  = 3'd3,
        MEM_WRITE = 3'd4,
        BRANCH    = 3'd5,
        JUMP      = 3'd6
    } instrClass_e;

endpackage

`default_nettype wire

// ==== rtl/mips_defs.svh ====
// MIPS decode stage shared parameters
// Data, register index and hazard count widths for the ID subsystem

`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Data word and program counter width
`define DATA_WIDTH 32

// Register file geometry
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// Hazard unit Tnew count width
`define TNEW_WIDTH 2

// Register written by JAL
`define LINK_REG 5'd31

`endif

// ==== rtl/nextPc.sv ====
// Next program counter unit
// Evaluates the six branch conditions and selects the next PC for
// branches, direct jumps and register jumps

`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module nextPc (
    input  mipsPkg::instrOp_e           op,
    input  wire logic [`DATA_WIDTH-1:0] rsData,
    input  wire logic [`DATA_WIDTH-1:0] rtData,
    input  wire logic [`DATA_WIDTH-1:0] pc,
    input  wire logic [15:0]            imm16,
    input  wire logic [25:0]            jmpAddr,
    output logic                        branchTaken,
    output logic [`DATA_WIDTH-1:0]      nextPcOut
);

    logic [`DATA_WIDTH-1:0] pcPlus4;
    logic [`DATA_WIDTH-1:0] branchTarget;
    logic                   rsNeg;
    logic                   rsZero;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign rsNeg        = rsData[`DATA_WIDTH-1];
    assign rsZero       = (rsData == '0);

    always_comb begin
        case (op)
            mipsPkg::BEQ:  branchTaken = (rsData == rtData);
            mipsPkg::BNE:  branchTaken = (rsData != rtData);
            mipsPkg::BGEZ: branchTaken = !rsNeg;
            mipsPkg::BGTZ: branchTaken = !rsNeg && !rsZero;
            mipsPkg::BLEZ: branchTaken = rsNeg || rsZero;
            mipsPkg::BLTZ: branchTaken = rsNeg;
            default:       branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        if (branchTaken) begin
            nextPcOut = branchTarget;
        end else if (op == mipsPkg::J || op == mipsPkg::JAL) begin
            nextPcOut = {pcPlus4[31:28], jmpAddr, 2'b00};
        end else if (op == mipsPkg::JR || op == mipsPkg::JALR) begin
            nextPcOut = rsData;
        end else begin
            nextPcOut = pcPlus4;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
// General register file
// 32 x 32 registers, two combinational read ports and one write port,
// with write-through from the write-back port and register 0 tied to zero

`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module regFile (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire logic [`REG_ADDR_WIDTH-1:0] rdAddr1,
    input  wire logic [`REG_ADDR_WIDTH-1:0] rdAddr2,
    output logic [`DATA_WIDTH-1:0]          rdData1,
    output logic [`DATA_WIDTH-1:0]          rdData2,
    input  wire logic                       wbEn,
    input  wire logic [`REG_ADDR_WIDTH-1:0] wbAddr,
    input  wire logic [`DATA_WIDTH-1:0]     wbData
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    // Same-cycle write-back bypasses the array except for register 0
    assign rdData1 = (wbEn && wbAddr == rdAddr1 && wbAddr != '0) ? wbData : regs[rdAddr1];
    assign rdData2 = (wbEn && wbAddr == rdAddr2 && wbAddr != '0) ? wbData : regs[rdAddr2];

    // Register 0 reads as zero even while it is the write-back target
    assert property (@(posedge clk) disable iff (!rstN)
        (rdAddr1 == '0) |-> (rdData1 == '0));
    assert property (@(posedge clk) disable iff (!rstN)
        (rdAddr2 == '0) |-> (rdData2 == '0));

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
rtl/mipsPkg.sv
rtl/instrDecoder.sv
rtl/instrClassify.sv
rtl/regFile.sv
rtl/nextPc.sv
rtl/decodeStage.sv
rtl/decodeTop.sv
testbench/decodeTb.sv

// ==== testbench/decodeTb.sv ====
// Decode subsystem testbench
// Reads stimulus and expected results from a hex data file, drives the
// DUT on the falling clock edge and checks combinational outputs in the
// same cycle and ID/EX outputs one cycle later

`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module decodeTb;

    localparam int WORDS = 10;
    localparam int MAX_STEPS = 64;
    localparam int RESET_CYCLES = 3;

    logic clk;
    logic rstN;
    logic stall;
    logic clr;
    logic wbEn;
    logic [`TNEW_WIDTH-1:0] tnewId;
    logic [`REG_ADDR_WIDTH-1:0] fwdAddrEx;
    logic [`REG_ADDR_WIDTH-1:0] fwdAddrMem;
    logic [`REG_ADDR_WIDTH-1:0] wbAddr;
    logic [`DATA_WIDTH-1:0] fwdDataEx;
    logic [`DATA_WIDTH-1:0] fwdDataMem;
    logic [`DATA_WIDTH-1:0] wbData;
    logic [`DATA_WIDTH-1:0] pcId;
    logic [31:0] instrId;
    mipsPkg::instrOp_e instrOpId;
    mipsPkg::instrOp_e opEx;
    logic [`REG_ADDR_WIDTH-1:0] rsId;
    logic [`REG_ADDR_WIDTH-1:0] rtId;
    logic branchTaken;
    logic [`DATA_WIDTH-1:0] nextPcOut;
    logic [`DATA_WIDTH-1:0] pcEx;
    logic [`DATA_WIDTH-1:0] rsDataEx;
    logic [`DATA_WIDTH-1:0] rtDataEx;
    logic [15:0] imm16Ex;
    logic [4:0] shamtEx;
    logic [`REG_ADDR_WIDTH-1:0] rsEx;
    logic [`REG_ADDR_WIDTH-1:0] rtEx;
    logic [`REG_ADDR_WIDTH-1:0] regWriteAddrEx;
    logic [`DATA_WIDTH-1:0] regWriteDataEx;
    logic [`TNEW_WIDTH-1:0] tnewEx;

    logic [31:0] vec [WORDS*MAX_STEPS];
    int nSteps = 0;
    int errors = 0;
    int stepErrors = 0;
    int cycles = 0;
    int limit = 0;

    // Reference register contents and the ID/EX fields not listed in the data file
    logic [`DATA_WIDTH-1:0] regModel [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] pcExp;
    logic [`DATA_WIDTH-1:0] rtDataExp;
    logic [31:0] instrExp;

    decodeTop u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Cycle budget, set once the data file is read
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic checkOp(input string name, input mipsPkg::instrOp_e exp,
                           input mipsPkg::instrOp_e act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %s got %s", $time, name, exp.name(), act.name());
            stepErrors++;
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
            stepErrors++;
        end
    endtask

    task automatic checkAddr(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %0d got %0d", $time, name, exp, act);
            stepErrors++;
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %b got %b", $time, name, exp, act);
            stepErrors++;
        end
    endtask

    // Operand seen in ID: EX result, then MEM result, then register file
    function automatic logic [31:0] operandValue(input logic [4:0] idx);
        logic [31:0] value;
        if (idx == 5'd0) begin
            value = '0;
        end else if (fwdAddrEx == idx) begin
            value = fwdDataEx;
        end else if (fwdAddrMem == idx) begin
            value = fwdDataMem;
        end else if (wbEn && wbAddr == idx) begin
            value = wbData;
        end else begin
            value = regModel[idx];
        end
        return value;
    endfunction

    task automatic applyStep(input int s);
        logic [31:0] ctl;
        ctl = vec[s*WORDS];
        clr = ctl[26];
        stall = ctl[25];
        wbEn = ctl[24];
        wbAddr = ctl[20:16];
        fwdAddrEx = ctl[12:8];
        fwdAddrMem = ctl[4:0];
        wbData = vec[s*WORDS+1];
        fwdDataEx = vec[s*WORDS+2];
        fwdDataMem = vec[s*WORDS+3];
        pcId = vec[s*WORDS+4];
        instrId = vec[s*WORDS+5];
        tnewId = vec[s*WORDS+6][17:16];
    endtask

    // Next ID/EX contents under clear and stall, then the write-back
    task automatic updateModel();
        if (clr) begin
            pcExp = '0;
            instrExp = '0;
            rtDataExp = '0;
        end else if (!stall) begin
            pcExp = pcId;
            instrExp = instrId;
            rtDataExp = operandValue(instrId[20:16]);
        end
        if (wbEn && wbAddr != 5'd0) begin
            regModel[wbAddr] = wbData;
        end
    endtask

    // Same-cycle outputs, fields come straight from the MIPS word layout
    task automatic checkComb(input int s);
        logic [31:0] expA;
        logic [31:0] instr;
        expA = vec[s*WORDS+6];
        instr = vec[s*WORDS+5];
        checkWord("nextPcOut", vec[s*WORDS+7], nextPcOut);
        checkBit("branchTaken", expA[20], branchTaken);
        checkAddr("rsId", instr[25:21], rsId);
        checkAddr("rtId", instr[20:16], rtId);
        if (vec[s*WORDS][31:28] == 4'h1) begin
            checkOp("instrOpId", mipsPkg::instrOp_e'(expA[29:24]), instrOpId);
        end
    endtask

    task automatic checkLatched(input int s);
        logic [31:0] expA;
        expA = vec[s*WORDS+6];
        checkOp("opEx", mipsPkg::instrOp_e'(expA[29:24]), opEx);
        checkAddr("regWriteAddrEx", expA[12:8], regWriteAddrEx);
        checkWord("regWriteDataEx", vec[s*WORDS+9], regWriteDataEx);
        checkWord("rsDataEx", vec[s*WORDS+8], rsDataEx);
        checkWord("rtDataEx", rtDataExp, rtDataEx);
        checkAddr("tnewEx", {3'b000, expA[1:0]}, {3'b000, tnewEx});
        checkWord("pcEx", pcExp, pcEx);
        checkAddr("rsEx", instrExp[25:21], rsEx);
        checkAddr("rtEx", instrExp[20:16], rtEx);
        checkWord("imm16Ex", {16'h0000, instrExp[15:0]}, {16'h0000, imm16Ex});
        checkAddr("shamtEx", instrExp[10:6], shamtEx);
    endtask

    initial begin
        rstN = 1'b0;
        stall = 1'b0;
        clr = 1'b0;
        wbEn = 1'b0;
        wbAddr = '0;
        wbData = '0;
        tnewId = '0;
        fwdAddrEx = '0;
        fwdDataEx = '0;
        fwdAddrMem = '0;
        fwdDataMem = '0;
        pcId = '0;
        instrId = '0;
        pcExp = '0;
        instrExp = '0;
        rtDataExp = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            regModel[i] = '0;
        end
        $readmemh("testbench/decode_testdata.txt", vec);
        while (nSteps < MAX_STEPS && vec[nSteps*WORDS][31:28] !== 4'hF) begin
            nSteps++;
        end
        limit = 4 * nSteps + RESET_CYCLES;
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;
        for (int s = 0; s < nSteps; s++) begin
            stepErrors = 0;
            applyStep(s);
            #1;
            checkComb(s);
            updateModel();
            @(negedge clk);
            checkLatched(s);
            if (stepErrors == 0) begin
                $display("step %0d kind %0h: ok", s, vec[s*WORDS][31:28]);
            end else begin
                $display("step %0d kind %0h: mismatch", s, vec[s*WORDS][31:28]);
            end
            errors += stepErrors;
        end
        $display("steps run %0d, failed checks %0d", nSteps, errors);
        if (nSteps == 0 || nSteps >= MAX_STEPS) begin
            $display("Data file held no steps or lacks its end marker");
        end
        if (errors == 0 && nSteps > 0 && nSteps < MAX_STEPS) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/decode_testdata.txt ====
// ctl(kind,flags clr4 stall2 wbEn1,wbAddr,fwdAddrEx,fwdAddrMem) wbData fwdDataEx fwdDataMem pc
// instr expA(op,taken,tnewIn,dest,tnewEx) nextPc rsDataEx regWriteDataEx, kind F ends the file
11050000 11110005 00000000 00000000 00400000 00A61820 01020301 00400004 11110005 00000000
11000000 DEADBEEF 00000000 00000000 00400004 34A71234 16000700 00400008 11110005 00000000
10000000 00000000 AAAAAAAA BBBBBBBB 00400008 00054021 03030802 0040000C 00000000 00000000
10000505 00000000 EEEE0001 CCCC0001 0040000C 00A64822 02010900 00400010 EEEE0001 00000000
10000605 00000000 EEEE0002 CCCC0002 00400010 00A64822 02000900 00400014 CCCC0002 00000000
10000000 00000000 00000000 00000000 00400014 3C0AABCD 18020A01 00400018 00000000 ABCD0000
10000000 00000000 00000000 00000000 00400018 8CAB0004 1B030B02 0040001C 11110005 00000000
10000000 00000000 00000000 00000000 0040001C ACAB0008 20000000 00400020 11110005 00000000
10000000 00000000 00000000 00000000 00400020 10A50003 23100000 00400030 11110005 00000000
10000000 00000000 00000000 00000000 00400024 14A50003 24000000 00400028 11110005 00000000
10000000 00000000 00000000 00000000 00400028 14A0FFFF 24100000 00400028 11110005 00000000
10000000 00000000 00000000 00000000 0040002C 18000002 25100000 00400038 00000000 00000000
10000000 00000000 00000000 00000000 00400030 18A00002 25000000 00400034 11110005 00000000
10000000 00000000 00000000 00000000 00400034 1CA00002 26100000 00400040 11110005 00000000
10000000 00000000 00000000 00000000 00400038 1C000002 26000000 0040003C 00000000 00000000
10000000 00000000 00000000 00000000 0040003C 04010004 27100000 00400050 00000000 00000000
10000C00 00000000 80000000 00000000 00400040 05810004 27000000 00400044 80000000 00000000
10000C00 00000000 80000000 00000000 00400044 05800004 28100000 00400058 80000000 00000000
10000000 00000000 00000000 00000000 00400048 04A00004 28000000 0040004C 11110005 00000000
10000000 00000000 00000000 00000000 0040004C 08100000 29000000 00400000 00000000 00000000
10000000 00000000 00000000 00000000 00400050 0C100010 2A021F01 00400040 00000000 00400058
10000000 00000000 00000000 00000000 00400054 00A00008 11000000 11110005 11110005 00000000
10000000 00000000 00000000 00000000 00400058 00A0F809 12001F00 11110005 11110005 00400060
22000000 00000000 00000000 00000000 0040005C 00A61820 12031F00 00400060 11110005 00400060
26000000 00000000 00000000 00000000 00400060 00A61820 00020000 00400064 00000000 00000000
24000000 00000000 00000000 00000000 00400064 3C0AABCD 00020000 00400068 00000000 00000000
10000000 00000000 00000000 00000000 00400068 00000000 00000000 0040006C 00000000 00000000
F0000000
